// File: Makefile
# Verilator build and run of the AXI read subordinate testbench
# Any variable below can be overridden on the make command line

VERILATOR ?= verilator
TOP       ?= tb_axi_rd_sub
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# Build, run, then decide the result from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: compile.f
hw/axi_rd_pkg.sv
hw/rd_txn_ctrl.sv
hw/rd_beat_counter.sv
hw/rd_addr_gen.sv
hw/rd_ctx_pipe.sv
hw/rd_skid_buffer.sv
hw/axi_rd_sub.sv
testbench/axi_rd_sub_checker.sv
testbench/tb_axi_rd_sub.sv

// File: hw/axi_rd_pkg.sv
// Shared widths, encodings and payload structs for the AXI read subordinate
// Widths are fixed here since the packed structs depend on them
// WRAP and reserved burst codes are handled as INCR by the address generator

package axi_rd_pkg;

    // ------------------------------
    // Widths
    // ------------------------------
    parameter int ADDR_W = 32;
    parameter int DATA_W = 32;
    // Byte offset bits inside one data word
    parameter int BYTE_W = $clog2(DATA_W / 8);
    parameter int ID_W   = 4;
    parameter int LEN_W  = 8;
    parameter int SIZE_W = 3;

    // ------------------------------
    // Encodings
    // ------------------------------
    typedef enum logic [1:0] {
        FIXED = 2'd0,
        INCR  = 2'd1,
        WRAP  = 2'd2
    } burst_e;

    // EXOKAY is never returned
    typedef enum logic [1:0] {
        OKAY   = 2'd0,
        SLVERR = 2'd2
    } resp_e;

    // ------------------------------
    // Payload structs
    // ------------------------------
    // One AR channel request
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        burst_e            burst;
        logic [SIZE_W-1:0] size;
        logic [LEN_W-1:0]  len;
        logic [ID_W-1:0]   id;
    } ar_req_t;

    // Context carried alongside each issued beat
    typedef struct packed {
        logic [ID_W-1:0] id;
        logic            last;
    } beat_ctx_t;

    // One R channel beat
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [ID_W-1:0]   id;
        resp_e             resp;
        logic              last;
    } r_beat_t;

    // Request towards the internal component, address is word aligned
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [ID_W-1:0]   id;
    } comp_req_t;

endpackage

// File: hw/axi_rd_sub.sv
// Read-only AXI subordinate in front of a fixed-latency component
// One AR burst is walked at a time, R beats return in issue order
// Component rdata and err must belong to the beat issued C_LAT cycles earlier
`timescale 1ns/10ps

module axi_rd_sub #(
    parameter int C_LAT = 1
) (
    input  logic                            clk,
    input  logic                            rst_n,
    // AR channel
    input  logic                            i_ar_valid,
    input  axi_rd_pkg::ar_req_t             i_ar,
    output logic                            o_ar_ready,
    // R channel
    output logic                            o_r_valid,
    output axi_rd_pkg::r_beat_t             o_r,
    input  logic                            i_r_ready,
    // Component interface
    output logic                            o_comp_dv,
    output axi_rd_pkg::comp_req_t           o_comp,
    input  logic                            i_comp_hld,
    input  logic [axi_rd_pkg::DATA_W-1:0]   i_comp_rdata,
    input  logic                            i_comp_err
);

    // ------------------------------
    // Internal wiring
    // ------------------------------
    logic                   load;
    logic                   step;
    logic                   last;
    axi_rd_pkg::beat_ctx_t  beat_ctx;

    // Skid chain, index 0 is fed by the context pipe, C_LAT+1 meets the R channel
    logic [C_LAT+1:0]                 pipe_valid;
    logic [C_LAT+1:0]                 pipe_ready;
    axi_rd_pkg::r_beat_t [C_LAT+1:0]  pipe_beat;

    // Acceptance and issue decisions
    rd_txn_ctrl #(
        .C_LAT          (C_LAT)
    ) u_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_ar_valid     (i_ar_valid),
        .o_ar_ready     (o_ar_ready),
        .i_last         (last),
        .i_pipe_ready   (pipe_ready[C_LAT:0]),
        .i_comp_hld     (i_comp_hld),
        .o_comp_dv      (o_comp_dv),
        .o_load         (load),
        .o_step         (step)
    );

    rd_beat_counter u_cnt (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_load         (load),
        .i_step         (step),
        .i_len          (i_ar.len),
        .o_last         (last)
    );

    rd_addr_gen u_addr (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_load         (load),
        .i_step         (step),
        .i_ar           (i_ar),
        .o_comp         (o_comp)
    );

    // ID and last travel with the issue strobe
    assign beat_ctx = '{id: o_comp.id, last: last};

    rd_ctx_pipe #(
        .C_LAT          (C_LAT)
    ) u_ctx (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_step         (step),
        .i_ctx          (beat_ctx),
        .i_rdata        (i_comp_rdata),
        .i_err          (i_comp_err),
        .o_valid        (pipe_valid[0]),
        .o_beat         (pipe_beat[0])
    );

    // ------------------------------
    // Data pipeline
    // ------------------------------
    // One stage per beat that can be in flight, plus one
    for (genvar s = 0; s <= C_LAT; s++) begin : g_skid
        rd_skid_buffer u_skid (
            .clk        (clk),
            .rst_n      (rst_n),
            .i_valid    (pipe_valid[s]),
            .o_ready    (pipe_ready[s]),
            .i_beat     (pipe_beat[s]),
            .o_valid    (pipe_valid[s+1]),
            .i_ready    (pipe_ready[s+1]),
            .o_beat     (pipe_beat[s+1])
        );
    end

    assign pipe_ready[C_LAT+1] = i_r_ready;
    assign o_r_valid           = pipe_valid[C_LAT+1];
    assign o_r                 = pipe_beat[C_LAT+1];

endmodule

// File: hw/rd_addr_gen.sv
// Burst address walker for FIXED and INCR bursts
// arsize is assumed not to exceed the data bus width
// WRAP and reserved burst codes step like INCR
`timescale 1ns/10ps

module rd_addr_gen (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      i_load,
    input  logic                      i_step,
    input  axi_rd_pkg::ar_req_t       i_ar,
    output axi_rd_pkg::comp_req_t     o_comp
);

    logic [axi_rd_pkg::ADDR_W-1:0]  addr_q;
    logic [axi_rd_pkg::ADDR_W-1:0]  incr;
    logic [axi_rd_pkg::SIZE_W-1:0]  size_q;
    axi_rd_pkg::burst_e             burst_q;
    logic [axi_rd_pkg::ID_W-1:0]    id_q;

    // Bytes per beat, 2**size
    always_comb begin
        incr         = '0;
        incr[size_q] = 1'b1;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_q  <= '0;
            size_q  <= '0;
            burst_q <= axi_rd_pkg::FIXED;
            id_q    <= '0;
        end else if (i_load) begin
            addr_q  <= i_ar.addr;
            size_q  <= i_ar.size;
            burst_q <= i_ar.burst;
            id_q    <= i_ar.id;
        end else if (i_step && (burst_q != axi_rd_pkg::FIXED)) begin
            // Full byte address advances, so narrow beats share a word
            addr_q  <= addr_q + incr;
        end
    end

    // Component only sees word aligned addresses
    always_comb begin
        o_comp.addr = {addr_q[axi_rd_pkg::ADDR_W-1:axi_rd_pkg::BYTE_W],
                       {axi_rd_pkg::BYTE_W{1'b0}}};
        o_comp.id   = id_q;
    end

endmodule

// File: hw/rd_beat_counter.sv
// Beats still to be issued in the active burst
// Holds at zero once the burst has been fully issued
`timescale 1ns/10ps

module rd_beat_counter (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           i_load,
    input  logic                           i_step,
    input  logic [axi_rd_pkg::LEN_W-1:0]   i_len,
    output logic                           o_last
);

    logic [axi_rd_pkg::LEN_W-1:0] cnt;

    // Load takes priority over a coincident step from the old burst
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (i_load) begin
            cnt <= i_len;
        end else if (i_step && (cnt != '0)) begin
            cnt <= cnt - 1'b1;
        end
    end

    // Zero left means the beat now presented is the last one
    assign o_last = (cnt == '0);

endmodule

// File: hw/rd_ctx_pipe.sv
// Delays beat context by the component latency and merges read data
// With C_LAT of 0 the context passes straight through
`timescale 1ns/10ps

module rd_ctx_pipe #(
    parameter int C_LAT = 1
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            i_step,
    input  axi_rd_pkg::beat_ctx_t           i_ctx,
    input  logic [axi_rd_pkg::DATA_W-1:0]   i_rdata,
    input  logic                            i_err,
    output logic                            o_valid,
    output axi_rd_pkg::r_beat_t             o_beat
);

    // Stage 0 is the issue cycle itself
    logic [C_LAT:0]                   vld;
    axi_rd_pkg::beat_ctx_t [C_LAT:0]  ctx;

    assign vld[0] = i_step;
    assign ctx[0] = i_ctx;

    // One register stage per cycle of latency, several beats may be in flight
    for (genvar k = 1; k <= C_LAT; k++) begin : g_stage
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                vld[k] <= 1'b0;
            end else begin
                vld[k] <= vld[k-1];
            end
        end

        // Context is only qualified by the strobe
        always_ff @(posedge clk) begin
            ctx[k] <= ctx[k-1];
        end
    end

    // Join context with the component's answer
    assign o_valid = vld[C_LAT];
    always_comb begin
        o_beat.data = i_rdata;
        o_beat.id   = ctx[C_LAT].id;
        o_beat.resp = i_err ? axi_rd_pkg::SLVERR : axi_rd_pkg::OKAY;
        o_beat.last = ctx[C_LAT].last;
    end

endmodule

// File: hw/rd_skid_buffer.sv
// Skid buffer for one R beat with a registered ready
// Empty and unstalled it is a combinational pass-through
// A beat arriving during a downstream stall is parked and drained first
`timescale 1ns/10ps

module rd_skid_buffer (
    input  logic                   clk,
    input  logic                   rst_n,
    // Upstream side
    input  logic                   i_valid,
    output logic                   o_ready,
    input  axi_rd_pkg::r_beat_t    i_beat,
    // Downstream side
    output logic                   o_valid,
    input  logic                   i_ready,
    output axi_rd_pkg::r_beat_t    o_beat
);

    // ------------------------------
    // Spare slot
    // ------------------------------
    logic                  skid_valid;
    axi_rd_pkg::r_beat_t   skid_beat;
    logic                  park;

    // Incoming beat that downstream cannot take this cycle
    assign park = i_valid && !skid_valid && !i_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            skid_valid <= 1'b0;
        end else if (skid_valid && i_ready) begin
            // Parked beat leaves first
            skid_valid <= 1'b0;
        end else if (park) begin
            skid_valid <= 1'b1;
        end
    end

    // Payload captured only when parking
    always_ff @(posedge clk) begin
        if (park) begin
            skid_beat <= i_beat;
        end
    end

    // Ready comes straight from a flop so the chain has no long ready path
    assign o_ready = !skid_valid;

    // ------------------------------
    // Output mux
    // ------------------------------
    // Parked beat has priority, it is older than anything upstream
    assign o_valid = skid_valid || i_valid;
    assign o_beat  = skid_valid ? skid_beat : i_beat;

endmodule

// File: hw/rd_txn_ctrl.sv
// Burst control FSM, decides AR acceptance and component issue
// Issue is held off until every skid stage has room for a beat
`timescale 1ns/10ps

module rd_txn_ctrl #(
    parameter int C_LAT = 1
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             i_ar_valid,
    output logic             o_ar_ready,
    input  logic             i_last,
    input  logic [C_LAT:0]   i_pipe_ready,
    input  logic             i_comp_hld,
    output logic             o_comp_dv,
    output logic             o_load,
    output logic             o_step
);

    typedef enum logic {
        IDLE   = 1'b0,
        ACTIVE = 1'b1
    } state_e;

    state_e state;
    logic   final_beat;

    // Room for a beat in every stage covers the worst case stall
    assign o_comp_dv  = (state == ACTIVE) && (&i_pipe_ready);
    assign o_step     = o_comp_dv && !i_comp_hld;
    // Final beat of the burst leaves the component interface this cycle
    assign final_beat = o_step && i_last;

    // Next burst may start in the same cycle the last beat is issued
    assign o_ar_ready = (state == IDLE) || final_beat;
    assign o_load     = i_ar_valid && o_ar_ready;

    // ------------------------------
    // State register
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else if (o_load) begin
            // Acceptance wins over a coincident final beat
            state <= ACTIVE;
        end else if (final_beat) begin
            state <= IDLE;
        end
    end

endmodule

// File: testbench/axi_rd_sub_checker.sv
// Bound assertions on the AR and R handshakes and the skid pipeline
// All checks are off while rst_n is low
`timescale 1ns/10ps

module axi_rd_sub_checker (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  i_ar_valid,
    input logic                  o_ar_ready,
    input logic                  o_r_valid,
    input axi_rd_pkg::r_beat_t   o_r,
    input logic                  i_r_ready,
    input logic                  o_comp_dv,
    input logic                  i_head_valid,
    input logic                  i_head_ready
);

    // A stalled R beat stays put
    a_r_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (o_r_valid && !i_r_ready) |=> (o_r_valid && $stable(o_r)))
        else $error("R beat changed or dropped while i_r_ready was low");

    // Master keeps the request up until it is taken
    a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (i_ar_valid && !o_ar_ready) |=> i_ar_valid)
        else $error("AR valid withdrawn before acceptance");

    // Context pipe cannot stall so the first skid stage must have room
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        i_head_valid |-> i_head_ready)
        else $error("Beat reached the first skid stage while it was full");

    // Control outputs never X once out of reset
    a_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown({o_ar_ready, o_r_valid, o_comp_dv}))
        else $error("Unknown value on a handshake output");

    a_r_known: assert property (@(posedge clk) disable iff (!rst_n)
        o_r_valid |-> !$isunknown(o_r))
        else $error("Unknown value on a valid R beat");

endmodule

bind axi_rd_sub axi_rd_sub_checker u_checker (
    .clk            (clk),
    .rst_n          (rst_n),
    .i_ar_valid     (i_ar_valid),
    .o_ar_ready     (o_ar_ready),
    .o_r_valid      (o_r_valid),
    .o_r            (o_r),
    .i_r_ready      (i_r_ready),
    .o_comp_dv      (o_comp_dv),
    .i_head_valid   (pipe_valid[0]),
    .i_head_ready   (pipe_ready[0])
);

// File: testbench/tb_axi_rd_sub.sv
// Testbench for the AXI read subordinate with the DUT built for C_LAT of 2
// Component model answers every beat two cycles after issue
// Random hld and rready share one $random stream seeded with 29
`timescale 1ns/10ps

module tb_axi_rd_sub;

    localparam int C_LAT   = 2;
    localparam int N_TESTS = 9;

    logic                           clk = 1'b0;
    logic                           rst_n = 1'b0;
    logic                           i_ar_valid = 1'b0;
    axi_rd_pkg::ar_req_t            i_ar = '0;
    logic                           o_ar_ready;
    logic                           o_r_valid;
    axi_rd_pkg::r_beat_t            o_r;
    logic                           i_r_ready = 1'b1;
    logic                           o_comp_dv;
    axi_rd_pkg::comp_req_t          o_comp;
    logic                           i_comp_hld = 1'b0;
    logic [axi_rd_pkg::DATA_W-1:0]  i_comp_rdata = '0;
    logic                           i_comp_err = 1'b0;

    // ------------------------------
    // Stimulus table and scoreboard
    // ------------------------------
    string                  t_name [N_TESTS];
    axi_rd_pkg::ar_req_t    t_req  [N_TESTS];
    bit                     t_rnd  [N_TESTS];

    // Expected traffic in issue order with an index back into the table
    axi_rd_pkg::comp_req_t  exp_comp [$];
    bit                     exp_comp_last [$];
    int                     exp_comp_idx [$];
    axi_rd_pkg::r_beat_t    exp_r [$];
    int                     exp_r_idx [$];

    // Component model delay line with one entry per cycle of latency
    logic [axi_rd_pkg::ADDR_W-1:0]  lat_addr [C_LAT];

    integer seed = 29;
    bit     rnd_mode = 1'b0;
    int     cycles = 0;
    int     limit = 0;
    int     overlap_cnt = 0;

    always #20 clk = ~clk;

    axi_rd_sub #(
        .C_LAT          (C_LAT)
    ) dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_ar_valid     (i_ar_valid),
        .i_ar           (i_ar),
        .o_ar_ready     (o_ar_ready),
        .o_r_valid      (o_r_valid),
        .o_r            (o_r),
        .i_r_ready      (i_r_ready),
        .o_comp_dv      (o_comp_dv),
        .o_comp         (o_comp),
        .i_comp_hld     (i_comp_hld),
        .i_comp_rdata   (i_comp_rdata),
        .i_comp_err     (i_comp_err)
    );

    // ------------------------------
    // Reporting and compare tasks
    // ------------------------------
    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_beat(input string name, input axi_rd_pkg::r_beat_t exp,
                              input axi_rd_pkg::r_beat_t act);
        if (act !== exp) begin
            fail_now($sformatf("ERROR %s expected data=%h id=%h resp=%0d last=%b %s",
                               name, exp.data, exp.id, exp.resp, exp.last,
                               $sformatf("actual data=%h id=%h resp=%0d last=%b",
                                         act.data, act.id, act.resp, act.last)));
        end
    endtask

    task automatic check_comp(input string name, input axi_rd_pkg::comp_req_t exp,
                              input axi_rd_pkg::comp_req_t act);
        if (act !== exp) begin
            fail_now($sformatf("ERROR %s expected addr=%h id=%h actual addr=%h id=%h",
                               name, exp.addr, exp.id, act.addr, act.id));
        end
    endtask

    task automatic flag_equals(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            fail_now($sformatf("ERROR %s expected %b actual %b", name, exp, act));
        end
    endtask

    // ------------------------------
    // Table and expected beats
    // ------------------------------
    task automatic set_entry(input int idx, input string name,
                             input logic [axi_rd_pkg::ADDR_W-1:0] addr,
                             input axi_rd_pkg::burst_e burst,
                             input logic [axi_rd_pkg::SIZE_W-1:0] size,
                             input logic [axi_rd_pkg::LEN_W-1:0] len,
                             input logic [axi_rd_pkg::ID_W-1:0] id, input bit rnd);
        t_name[idx]       = name;
        t_req[idx].addr   = addr;
        t_req[idx].burst  = burst;
        t_req[idx].size   = size;
        t_req[idx].len    = len;
        t_req[idx].id     = id;
        t_rnd[idx]        = rnd;
    endtask

    // INCR steps the byte address by 2**size and FIXED holds it before word alignment
    task automatic queue_expected(input int idx);
        axi_rd_pkg::ar_req_t            req;
        axi_rd_pkg::comp_req_t          c;
        axi_rd_pkg::r_beat_t            b;
        logic [axi_rd_pkg::ADDR_W-1:0]  byte_addr;
        req = t_req[idx];
        for (int i = 0; i <= int'(req.len); i++) begin
            if (req.burst == axi_rd_pkg::FIXED) begin
                byte_addr = req.addr;
            end else begin
                byte_addr = req.addr + (i << req.size);
            end
            c.addr = byte_addr;
            c.addr[axi_rd_pkg::BYTE_W-1:0] = '0;
            c.id   = req.id;
            b.data = c.addr ^ 32'h5A5A_0000;
            b.id   = req.id;
            b.resp = c.addr[12] ? axi_rd_pkg::SLVERR : axi_rd_pkg::OKAY;
            b.last = (i == int'(req.len));
            exp_comp.push_back(c);
            exp_comp_last.push_back(b.last);
            exp_comp_idx.push_back(idx);
            exp_r.push_back(b);
            exp_r_idx.push_back(idx);
        end
    endtask

    // Present one request and hold it until the handshake
    task automatic drive_request(input int idx);
        @(negedge clk);
        rnd_mode   = t_rnd[idx];
        queue_expected(idx);
        i_ar       = t_req[idx];
        i_ar_valid = 1'b1;
        @(posedge clk);
        while (!o_ar_ready) begin
            @(posedge clk);
        end
    endtask

    // ------------------------------
    // Component model and random drivers
    // ------------------------------
    always @(posedge clk) begin
        lat_addr[0] <= o_comp.addr;
        for (int k = 1; k < C_LAT; k++) begin
            lat_addr[k] <= lat_addr[k-1];
        end
    end

    // Answer for the beat issued C_LAT cycles back
    always @(negedge clk) begin
        if (rst_n) begin
            if (rnd_mode) begin
                i_r_ready  = ($random(seed) & 3) != 0;
                i_comp_hld = ($random(seed) & 3) == 0;
            end else begin
                i_r_ready  = 1'b1;
                i_comp_hld = 1'b0;
            end
            i_comp_rdata = lat_addr[C_LAT-1] ^ 32'h5A5A_0000;
            i_comp_err   = lat_addr[C_LAT-1][12];
        end
    end

    // ------------------------------
    // Monitors
    // ------------------------------
    always @(posedge clk) begin
        if (rst_n && o_comp_dv && !i_comp_hld) begin
            if (exp_comp.size() == 0) begin
                fail_now("A component request was issued with no burst outstanding");
            end else begin
                // Waiting request must be taken in the final issue cycle
                if (exp_comp_last[0] && i_ar_valid) begin
                    flag_equals({t_name[exp_comp_idx[0]], " ar_ready at final issue"},
                                1'b1, o_ar_ready);
                    overlap_cnt++;
                end
                check_comp(t_name[exp_comp_idx[0]], exp_comp[0], o_comp);
                void'(exp_comp.pop_front());
                void'(exp_comp_last.pop_front());
                void'(exp_comp_idx.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        if (rst_n && o_r_valid && i_r_ready) begin
            if (exp_r.size() == 0) begin
                fail_now("An R beat came back with no beat expected");
            end else begin
                check_beat(t_name[exp_r_idx[0]], exp_r[0], o_r);
                void'(exp_r.pop_front());
                void'(exp_r_idx.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= limit) begin
            fail_now($sformatf("Timeout after %0d cycles with %0d R beats still missing",
                               cycles, exp_r.size()));
        end
    end

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        set_entry(0, "incr_len7_full",   32'h0000_0100, axi_rd_pkg::INCR,  3'd2, 8'd7, 4'd1, 0);
        set_entry(1, "fixed_len3",       32'h0000_020A, axi_rd_pkg::FIXED, 3'd2, 8'd3, 4'd2, 0);
        set_entry(2, "incr_narrow_odd",  32'h0000_0301, axi_rd_pkg::INCR,  3'd1, 8'd5, 4'd3, 0);
        set_entry(3, "slverr_bit12",     32'h0000_1040, axi_rd_pkg::INCR,  3'd2, 8'd3, 4'd4, 0);
        set_entry(4, "okay_after_err",   32'h0000_2040, axi_rd_pkg::INCR,  3'd2, 8'd2, 4'd5, 0);
        set_entry(5, "rand_incr_a",      32'h0000_0400, axi_rd_pkg::INCR,  3'd2, 8'd5, 4'd6, 1);
        set_entry(6, "rand_incr_err",    32'h0000_1800, axi_rd_pkg::INCR,  3'd2, 8'd4, 4'd7, 1);
        set_entry(7, "rand_fixed",       32'h0000_0510, axi_rd_pkg::FIXED, 3'd2, 8'd2, 4'd8, 1);
        set_entry(8, "rand_narrow",      32'h0000_0602, axi_rd_pkg::INCR,  3'd1, 8'd6, 4'd9, 1);
        // Four cycles per beat plus fixed slack
        limit = 200;
        for (int n = 0; n < N_TESTS; n++) begin
            limit += (int'(t_req[n].len) + 1) * 4;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(posedge clk);
        flag_equals("after_reset ar_ready", 1'b1, o_ar_ready);
        flag_equals("after_reset r_valid", 1'b0, o_r_valid);
        flag_equals("after_reset comp_dv", 1'b0, o_comp_dv);
        // Requests go back to back and each waits through the previous burst
        for (int n = 0; n < N_TESTS; n++) begin
            drive_request(n);
        end
        @(negedge clk);
        i_ar_valid = 1'b0;
        while ((exp_r.size() != 0) || (exp_comp.size() != 0)) begin
            @(posedge clk);
        end
        // Quiet period catches stray extra beats
        repeat (C_LAT + 4) @(posedge clk);
        if (overlap_cnt == 0) begin
            fail_now("No request was accepted in the cycle of a final beat");
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule
